/* hdl/data_ram.sv */
`default_nettype none

module data_ram
  import lsu_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic            clk,
  input  logic            en_i,
  input  logic            is_store_i,
  input  logic [7:0]      byte_mask_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic [XLEN-1:0] rword_o
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [XLEN-1:0]  mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;

  // Word index wraps onto the array by its low bits.
  assign idx = addr_i[IDX_W+2:3];

  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (is_store_i) begin
        for (int b = 0; b < 8; b++) begin
          if (byte_mask_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end else begin
        rword_o <= mem[idx];
      end
    end
  end

  a_store_mask: assert property (@(posedge clk)
    en_i && is_store_i |-> (byte_mask_i != 8'h00));

endmodule

`default_nettype wire

/* hdl/load_extend.sv */
`default_nettype none

module load_extend
  import lsu_pkg::*;
(
  input  mem_op_e         op_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] rword_i,
  output logic [XLEN-1:0] ldata_o
);

  logic [XLEN-1:0] shifted;

  // Bring the addressed lane down to byte 0.
  assign shifted = rword_i >> {addr_i[2:0], 3'b000};

  always_comb begin
    case (op_i)
      MEMOP_LB: begin
        ldata_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      MEMOP_LBU: begin
        ldata_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
      end
      MEMOP_LH: begin
        ldata_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      MEMOP_LHU: begin
        ldata_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
      end
      MEMOP_LW: begin
        ldata_o = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      MEMOP_LWU: begin
        ldata_o = {{(XLEN-32){1'b0}}, shifted[31:0]};
      end
      MEMOP_LD: begin
        ldata_o = shifted;
      end
      // Stores and no-ops return nothing.
      default: begin
        ldata_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/lsu_ctrl.sv */
`default_nettype none

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  input  logic            req_valid_i,
  input  mem_op_e         req_op_i,
  input  logic [XLEN-1:0] req_addr_i,
  input  logic [XLEN-1:0] req_wdata_i,
  output logic            req_ready_o,
  input  logic            misaligned_i,
  input  logic            timer_done_i,
  input  logic [XLEN-1:0] load_data_i,
  output logic            timer_start_o,
  output logic            mem_en_o,
  output logic            is_store_o,
  output mem_op_e         cur_op_o,
  output logic [XLEN-1:0] cur_addr_o,
  output logic [XLEN-1:0] cur_wdata_o,
  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_rdata_o,
  output logic            resp_err_o,
  input  logic            resp_ready_i
);

  lsu_state_e      state_q;
  lsu_state_e      state_d;
  mem_op_e         cur_op_q;
  logic [XLEN-1:0] cur_addr_q;
  logic [XLEN-1:0] cur_wdata_q;
  logic            cur_is_load;
  logic            resp_err_q;
  logic            resp_load_q;

  assign cur_is_load = cur_op_q inside {MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU,
                                        MEMOP_LW, MEMOP_LWU, MEMOP_LD};
  assign is_store_o  = cur_op_q inside {MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD};

  assign req_ready_o   = (state_q == ST_IDLE);
  assign timer_start_o = req_ready_o && req_valid_i;
  assign resp_valid_o  = (state_q == ST_RESP);

  // The access fires in the single cycle where the latency expires.
  assign mem_en_o = (state_q == ST_WAIT) && timer_done_i && !misaligned_i &&
                    (cur_op_q != MEMOP_NONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (req_valid_i) state_d = ST_WAIT;
      ST_WAIT: if (timer_done_i) state_d = ST_RESP;
      ST_RESP: if (resp_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q     <= ST_IDLE;
      cur_op_q    <= MEMOP_NONE;
      resp_err_q  <= 1'b0;
      resp_load_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (timer_start_o) begin
        cur_op_q <= req_op_i;
      end
      // Response flags are captured on the way into ST_RESP.
      if (state_q == ST_WAIT && timer_done_i) begin
        resp_err_q  <= misaligned_i;
        resp_load_q <= cur_is_load && !misaligned_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (timer_start_o) begin
      cur_addr_q  <= req_addr_i;
      cur_wdata_q <= req_wdata_i;
    end
  end

  assign cur_op_o    = cur_op_q;
  assign cur_addr_o  = cur_addr_q;
  assign cur_wdata_o = cur_wdata_q;

  // RAM read word is held while mem_en_o is low, so the mux output stays put.
  assign resp_rdata_o = resp_load_q ? load_data_i : '0;
  assign resp_err_o   = resp_err_q;

  a_resp_hold: assert property (@(posedge clk) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=>
      resp_valid_o && $stable(resp_rdata_o) && $stable(resp_err_o));

  // The latency expiry must land in ST_WAIT, or the access would be lost.
  a_done_in_wait: assert property (@(posedge clk) disable iff (reset_i)
    timer_done_i |-> (state_q == ST_WAIT));

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // Data and address width of the core.
  parameter int XLEN = 64;

  // Memory opcodes, shared with the golden vector file in this order.
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    // Loads.
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_LWU  = 4'd6,
    MEMOP_LD   = 4'd7,
    // Stores.
    MEMOP_SB   = 4'd8,
    MEMOP_SH   = 4'd9,
    MEMOP_SW   = 4'd10,
    MEMOP_SD   = 4'd11
  } mem_op_e;

  // Request/response FSM states.
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_WAIT = 2'd1,
    ST_RESP = 2'd2
  } lsu_state_e;

endpackage

`default_nettype wire

/* hdl/lsu_top.sv */
`default_nettype none

module lsu_top
  import lsu_pkg::*;
#(
  parameter int unsigned MEM_LATENCY = 2,
  parameter int unsigned RAM_WORDS   = 256
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  mem_op_e         req_op_i,
  input  logic [XLEN-1:0] req_addr_i,
  input  logic [XLEN-1:0] req_wdata_i,
  output logic            resp_valid_o,
  input  logic            resp_ready_i,
  output logic [XLEN-1:0] resp_rdata_o,
  output logic            resp_err_o
);

  mem_op_e         cur_op;
  logic [XLEN-1:0] cur_addr;
  logic [XLEN-1:0] cur_wdata;
  logic [7:0]      byte_mask;
  logic [XLEN-1:0] aligned_wdata;
  logic            misaligned;
  logic            timer_start;
  logic            timer_done;
  logic            mem_en;
  logic            is_store;
  logic [XLEN-1:0] rword;
  logic [XLEN-1:0] load_data;

  lsu_ctrl u_ctrl (
    .clk           (clk),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .req_ready_o   (req_ready_o),
    .misaligned_i  (misaligned),
    .timer_done_i  (timer_done),
    .load_data_i   (load_data),
    .timer_start_o (timer_start),
    .mem_en_o      (mem_en),
    .is_store_o    (is_store),
    .cur_op_o      (cur_op),
    .cur_addr_o    (cur_addr),
    .cur_wdata_o   (cur_wdata),
    .resp_valid_o  (resp_valid_o),
    .resp_rdata_o  (resp_rdata_o),
    .resp_err_o    (resp_err_o),
    .resp_ready_i  (resp_ready_i)
  );

  mem_wait_timer #(
    .MEM_LATENCY (MEM_LATENCY)
  ) u_timer (
    .clk     (clk),
    .reset_i (reset_i),
    .start_i (timer_start),
    .done_o  (timer_done)
  );

  store_align u_store_align (
    .op_i         (cur_op),
    .addr_i       (cur_addr),
    .wdata_i      (cur_wdata),
    .byte_mask_o  (byte_mask),
    .wdata_o      (aligned_wdata),
    .misaligned_o (misaligned)
  );

  load_extend u_load_extend (
    .op_i    (cur_op),
    .addr_i  (cur_addr),
    .rword_i (rword),
    .ldata_o (load_data)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .clk         (clk),
    .en_i        (mem_en),
    .is_store_i  (is_store),
    .byte_mask_i (byte_mask),
    .addr_i      (cur_addr),
    .wdata_i     (aligned_wdata),
    .rword_o     (rword)
  );

endmodule

`default_nettype wire

/* hdl/mem_wait_timer.sv */
`default_nettype none

module mem_wait_timer #(
  parameter int unsigned MEM_LATENCY = 2
) (
  input  logic clk,
  input  logic reset_i,
  input  logic start_i,
  output logic done_o
);

  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  logic [CNT_W-1:0] count_q;
  logic             done_q;

  // Done is registered, so it rises MEM_LATENCY edges after the start edge.
  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= (count_q == CNT_W'(1));
      if (start_i) begin
        count_q <= CNT_W'(MEM_LATENCY);
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign done_o = done_q;

  a_no_restart: assert property (@(posedge clk) disable iff (reset_i)
    start_i |-> (count_q == '0));

endmodule

`default_nettype wire

/* hdl/store_align.sv */
`default_nettype none

module store_align
  import lsu_pkg::*;
(
  input  mem_op_e         op_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic [7:0]      byte_mask_o,
  output logic [XLEN-1:0] wdata_o,
  output logic            misaligned_o
);

  logic [3:0]      size;
  logic [7:0]      base_mask;
  logic [XLEN-1:0] low_data;
  logic            is_store;

  assign is_store = op_i inside {MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD};

  // Access size in bytes, zero for no access.
  always_comb begin
    case (op_i)
      MEMOP_LB, MEMOP_LBU, MEMOP_SB: size = 4'd1;
      MEMOP_LH, MEMOP_LHU, MEMOP_SH: size = 4'd2;
      MEMOP_LW, MEMOP_LWU, MEMOP_SW: size = 4'd4;
      MEMOP_LD, MEMOP_SD:            size = 4'd8;
      default:                       size = 4'd0;
    endcase
  end

  always_comb begin
    case (size)
      4'd1: base_mask = 8'h01;
      4'd2: base_mask = 8'h03;
      4'd4: base_mask = 8'h0f;
      4'd8: base_mask = 8'hff;
      default: base_mask = 8'h00;
    endcase
  end

  // Keep only the bytes the store actually writes.
  always_comb begin
    case (size)
      4'd1: low_data = {56'b0, wdata_i[7:0]};
      4'd2: low_data = {48'b0, wdata_i[15:0]};
      4'd4: low_data = {32'b0, wdata_i[31:0]};
      default: low_data = wdata_i;
    endcase
  end

  assign byte_mask_o  = base_mask << addr_i[2:0];
  assign wdata_o      = is_store ? (low_data << {addr_i[2:0], 3'b000}) : '0;
  assign misaligned_o = (size != 4'd0) && ((addr_i[2:0] & (size[2:0] - 3'd1)) != 3'd0);

endmodule

`default_nettype wire

/* lsu_top.f */
hdl/lsu_pkg.sv
hdl/mem_wait_timer.sv
hdl/store_align.sv
hdl/load_extend.sv
hdl/data_ram.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
sim/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator from the project root.
verilator --binary --assert -f lsu_top.f --top-module lsu_tb -o lsu_sim \
  && ./obj_dir/lsu_sim > sim.log 2>&1 \
  || { echo "Build or simulation run did not complete, see sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "No pass message found in sim.log"; exit 1; }
echo "Simulation finished without errors"
exit 0

/* sim/lsu_golden.txt */
# Columns in hex: opcode address wdata expected_rdata expected_err
# Opcodes: 0 NONE, 1 LB, 2 LBU, 3 LH, 4 LHU, 5 LW, 6 LWU, 7 LD, 8 SB, 9 SH, a SW, b SD
b 0000000000000100 0123456789abcdef 0000000000000000 0
7 0000000000000100 0000000000000000 0123456789abcdef 0
b 0000000000000108 fedcba9876543210 0000000000000000 0
7 0000000000000108 0000000000000000 fedcba9876543210 0
8 0000000000000103 ffffffffffffffaa 0000000000000000 0
9 0000000000000106 0000000000008001 0000000000000000 0
7 0000000000000100 0000000000000000 80014567aaabcdef 0
1 0000000000000103 0000000000000000 ffffffffffffffaa 0
2 0000000000000103 0000000000000000 00000000000000aa 0
3 0000000000000106 0000000000000000 ffffffffffff8001 0
4 0000000000000106 0000000000000000 0000000000008001 0
a 000000000000010c 111111119abcdef0 0000000000000000 0
5 000000000000010c 0000000000000000 ffffffff9abcdef0 0
6 000000000000010c 0000000000000000 000000009abcdef0 0
3 0000000000000101 0000000000000000 0000000000000000 1
5 0000000000000102 0000000000000000 0000000000000000 1
7 0000000000000104 0000000000000000 0000000000000000 1
9 0000000000000105 000000000000ffff 0000000000000000 1
a 000000000000010a 00000000ffffffff 0000000000000000 1
b 0000000000000103 ffffffffffffffff 0000000000000000 1
7 0000000000000900 0000000000000000 80014567aaabcdef 0
7 0000000000000108 0000000000000000 9abcdef076543210 0
0 0000000000000000 0000000000000000 0000000000000000 0

/* sim/lsu_tb.sv */
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_LATENCY    = 2;
  localparam int RAM_WORDS      = 256;
  localparam int unsigned SEED  = 32'h8299_5397;
  localparam int unsigned STALL_MAX = 3;
  localparam int TIMEOUT_MARGIN = 100;

  logic            clk;
  logic            reset_i;
  logic            req_valid_i;
  logic            req_ready_o;
  mem_op_e         req_op_i;
  logic [XLEN-1:0] req_addr_i;
  logic [XLEN-1:0] req_wdata_i;
  logic            resp_valid_o;
  logic            resp_ready_i;
  logic [XLEN-1:0] resp_rdata_o;
  logic            resp_err_o;

  // Golden vectors, one entry per access.
  logic [3:0]      vec_op[$];
  logic [XLEN-1:0] vec_addr[$];
  logic [XLEN-1:0] vec_wdata[$];
  logic [XLEN-1:0] vec_rdata[$];
  logic            vec_err[$];

  int data_errors = 0;
  int timing_errors = 0;
  int protocol_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  lsu_top #(
    .MEM_LATENCY (MEM_LATENCY),
    .RAM_WORDS   (RAM_WORDS)
  ) DUT (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o)
  );

  always #5 clk = ~clk;

  task automatic print_counts();
    $display("Error counts: %0d data mismatches, %0d timing errors, %0d protocol errors",
             data_errors, timing_errors, protocol_errors);
  endtask

  // Limit is zero until the vectors are loaded.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      print_counts();
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic read_vectors(output bit opened);
    int              fd;
    int              code;
    logic [8*256-1:0] line;
    logic [3:0]      op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic            err;
    fd = $fopen("sim/lsu_golden.txt", "r");
    opened = (fd != 0);
    if (opened) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Comment and blank lines match no fields.
        if (code > 0) begin
          code = $sscanf(line, "%h %h %h %h %h", op, addr, wdata, rdata, err);
          if (code == 5) begin
            vec_op.push_back(op);
            vec_addr.push_back(addr);
            vec_wdata.push_back(wdata);
            vec_rdata.push_back(rdata);
            vec_err.push_back(err);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_vector(input int i);
    int              lat;
    int              stall;
    logic [XLEN-1:0] held_rdata;
    logic            held_err;
    req_op_i    = mem_op_e'(vec_op[i]);
    req_addr_i  = vec_addr[i];
    req_wdata_i = vec_wdata[i];
    req_valid_i = 1'b1;
    while (!req_ready_o) @(negedge clk);
    // The next rising edge is the acceptance edge.
    @(posedge clk);
    @(negedge clk);
    req_valid_i = 1'b0;
    lat = 0;
    while (!resp_valid_o) begin
      @(negedge clk);
      lat++;
    end
    if (lat != MEM_LATENCY + 1) begin
      $display("Vector %0d: response arrived %0d cycles after acceptance instead of %0d",
               i, lat, MEM_LATENCY + 1);
      timing_errors++;
    end
    if (resp_rdata_o !== vec_rdata[i]) begin
      $display("Mismatch resp_rdata_o vector %0d: expected %h, got %h",
               i, vec_rdata[i], resp_rdata_o);
      data_errors++;
    end
    if (resp_err_o !== vec_err[i]) begin
      $display("Mismatch resp_err_o vector %0d: expected %h, got %h", i, vec_err[i], resp_err_o);
      data_errors++;
    end
    held_rdata = resp_rdata_o;
    held_err   = resp_err_o;
    stall      = int'($urandom_range(STALL_MAX, 0));
    repeat (stall) begin
      @(negedge clk);
      if (!resp_valid_o || resp_rdata_o !== held_rdata || resp_err_o !== held_err) begin
        $display("Vector %0d: response dropped or changed while resp_ready_i was low", i);
        protocol_errors++;
      end
    end
    resp_ready_i = 1'b1;
    @(negedge clk);
    resp_ready_i = 1'b0;
    if (resp_valid_o || !req_ready_o) begin
      $display("Vector %0d: LSU did not return to idle after the response handshake", i);
      protocol_errors++;
    end
  endtask

  initial begin
    bit opened;
    clk          = 1'b0;
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = MEMOP_NONE;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    resp_ready_i = 1'b0;
    void'($urandom(SEED));
    read_vectors(opened);
    if (!opened) begin
      $display("Could not open the golden vector file sim/lsu_golden.txt");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      // Worst case per vector is the latency plus stalls and handshakes.
      cycle_limit = vec_op.size() * (MEM_LATENCY + 8) + TIMEOUT_MARGIN;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;
      if (vec_op.size() == 0) begin
        $display("No vectors were found in the golden file");
        protocol_errors++;
      end
      if (!req_ready_o || resp_valid_o) begin
        $display("LSU is not idle after reset");
        protocol_errors++;
      end
      for (int i = 0; i < vec_op.size(); i++) begin
        run_vector(i);
      end
      print_counts();
      if (data_errors + timing_errors + protocol_errors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
